// File: rtl/ig_pkg.sv
package ig_pkg;

    // ----------------------------------------
    // image geometry
    // ----------------------------------------
    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int NUM_PIX = IMG_W * IMG_H;
    localparam int COL_W   = $clog2(IMG_W);
    localparam int ROW_W   = $clog2(IMG_H);
    // one row plus the oldest pixel
    localparam int WIN_N     = IMG_W + 1;
    localparam int WIN_CNT_W = $clog2(WIN_N + 1);

    // data and address widths
    localparam int PIX_W  = 8;
    localparam int GRAD_W = 10;
    localparam int ADDR_W = 6;

    // ----------------------------------------
    // flow control
    // ----------------------------------------
    localparam int STREAM_CREDITS = 4;
    localparam int OUT_CREDITS    = 4;
    localparam int CRED_W         = $clog2(STREAM_CREDITS + 1);
    localparam int PTR_W          = $clog2(STREAM_CREDITS);
    // write credits from outside may pile up while idle
    localparam int WCRED_W        = 8;

    typedef logic [PIX_W-1:0]  pixel_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // gx in the upper half of the memory word
    typedef struct packed {
        logic signed [GRAD_W-1:0] gx;
        logic signed [GRAD_W-1:0] gy;
    } grad_t;

endpackage

// File: rtl/credit_stream_if.sv
`timescale 1ns/1ps

// one credit-controlled stream
// source spends a credit per valid, sink returns one per freed slot
interface credit_stream_if #(
    parameter type T = logic
);

    logic valid;
    T     data;
    // final item of the image
    logic last;
    // one-cycle pulse, one buffer slot
    logic credit;

    modport src (
        output valid,
        output data,
        output last,
        input  credit
    );

    modport snk (
        input  valid,
        input  data,
        input  last,
        output credit
    );

endinterface

// File: rtl/pixel_fetcher.sv
`timescale 1ns/1ps

module pixel_fetcher
    import ig_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    output logic         img_rd,
    output addr_t        img_addr,
    input  pixel_t       img_di,
    credit_stream_if.src pix_s
);

    logic              running;
    addr_t             rd_addr;
    logic [CRED_W-1:0] credits;
    // read issued last cycle, data arrives now
    logic              rd_q;
    logic              last_q;

    // ----------------------------------------
    // read issue
    // ----------------------------------------
    // a read in flight already owns one credit
    assign img_rd   = running && (credits > CRED_W'(rd_q));
    assign img_addr = rd_addr;

    // returned pixel goes straight onto the stream, slot reserved at read time
    assign pix_s.valid = rd_q;
    assign pix_s.data  = img_di;
    assign pix_s.last  = last_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            rd_addr <= '0;
            credits <= CRED_W'(STREAM_CREDITS);
            rd_q    <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            rd_q   <= img_rd;
            last_q <= img_rd && (rd_addr == addr_t'(NUM_PIX - 1));
            if (start) begin
                running <= 1'b1;
                rd_addr <= '0;
                credits <= CRED_W'(STREAM_CREDITS);
            end else begin
                if (img_rd) begin
                    rd_addr <= rd_addr + 1'b1;
                    // final address, stop walking
                    if (rd_addr == addr_t'(NUM_PIX - 1)) begin
                        running <= 1'b0;
                    end
                end
                // valid spends, credit pulse refunds
                credits <= credits - CRED_W'(pix_s.valid) + CRED_W'(pix_s.credit);
            end
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // read decision one cycle back must have left a credit for this pixel
    a_valid_has_credit: assert property (@(posedge clk) disable iff (reset)
        pix_s.valid |-> (credits != '0));

endmodule

// File: rtl/gradient_engine.sv
`timescale 1ns/1ps

module gradient_engine
    import ig_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    credit_stream_if.snk pix_s,
    credit_stream_if.src grad_s
);

    // input fifo, depth equals the upstream credits
    pixel_t            fifo_mem [STREAM_CREDITS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CRED_W-1:0] fifo_cnt;

    // window, index 0 is the oldest pixel
    pixel_t               win [WIN_N];
    logic [WIN_CNT_W-1:0] win_cnt;
    logic [WIN_CNT_W-1:0] push_pos;
    // position of the oldest pixel
    logic [COL_W-1:0]     col;
    logic [ROW_W-1:0]     row;

    logic              last_rcvd;
    logic              flushing;
    logic [CRED_W-1:0] out_cred;
    // arrival count, only for the last check
    addr_t             in_idx;

    logic  emit;
    logic  push;
    logic  last_col;
    logic  last_row;
    grad_t grad;

    // zero-extend a pixel to one signed gradient component
    function automatic logic signed [GRAD_W-1:0] ext(input pixel_t p);
        return $signed({{(GRAD_W - PIX_W){1'b0}}, p});
    endfunction

    // ----------------------------------------
    // window control
    // ----------------------------------------
    // all pixels are in the window once last is in and the fifo is drained
    assign flushing = last_rcvd && (fifo_cnt == '0);
    assign last_col = (col == COL_W'(IMG_W - 1));
    assign last_row = (row == ROW_W'(IMG_H - 1));

    // full window holds the pixel below, flush covers the last row
    assign emit = (out_cred != '0) &&
                  ((win_cnt == WIN_CNT_W'(WIN_N)) || (flushing && (win_cnt != '0)));
    // emit frees a slot in the same cycle
    assign push     = (fifo_cnt != '0) && ((win_cnt != WIN_CNT_W'(WIN_N)) || emit);
    assign push_pos = win_cnt - WIN_CNT_W'(emit);

    // right neighbour at 1, pixel below at IMG_W
    always_comb begin
        grad.gx = last_col ? '0 : ext(win[1]) - ext(win[0]);
        grad.gy = last_row ? '0 : ext(win[IMG_W]) - ext(win[0]);
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_cnt     <= '0;
            win_cnt      <= '0;
            col          <= '0;
            row          <= '0;
            last_rcvd    <= 1'b0;
            out_cred     <= CRED_W'(STREAM_CREDITS);
            in_idx       <= '0;
            pix_s.credit <= 1'b0;
            grad_s.valid <= 1'b0;
            grad_s.last  <= 1'b0;
        end else begin
            if (pix_s.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
                in_idx <= in_idx + 1'b1;
                if (pix_s.last) begin
                    last_rcvd <= 1'b1;
                end
            end
            if (push) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + CRED_W'(pix_s.valid) - CRED_W'(push);
            win_cnt  <= win_cnt + WIN_CNT_W'(push) - WIN_CNT_W'(emit);
            out_cred <= out_cred - CRED_W'(emit) + CRED_W'(grad_s.credit);
            // raster position of the next oldest pixel
            if (emit) begin
                if (last_col) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
            // slot returned once the pixel leaves the fifo
            pix_s.credit <= push;
            grad_s.valid <= emit;
            grad_s.last  <= emit && last_col && last_row;
        end
    end

    // ----------------------------------------
    // payload
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (pix_s.valid) begin
            fifo_mem[wr_ptr] <= pix_s.data;
        end
        for (int k = 0; k < WIN_N - 1; k++) begin
            if (emit) begin
                win[k] <= win[k + 1];
            end
        end
        // newest pixel lands behind the shifted tail
        if (push) begin
            win[push_pos] <= fifo_mem[rd_ptr];
        end
        if (emit) begin
            grad_s.data <= grad;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // fetcher credits keep the fifo from overflowing
    a_fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
        pix_s.valid |-> (fifo_cnt != CRED_W'(STREAM_CREDITS)));

    // last marks exactly the final pixel of the image
    a_last_at_end: assert property (@(posedge clk) disable iff (reset)
        pix_s.valid |-> (pix_s.last == (in_idx == addr_t'(NUM_PIX - 1))));

endmodule

// File: rtl/grad_writer.sv
`timescale 1ns/1ps

module grad_writer
    import ig_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    credit_stream_if.snk grad_s,
    input  logic         grad_credit,
    output logic         grad_wr,
    output addr_t        grad_addr,
    output grad_t        grad_do,
    output logic         done
);

    // gradient fifo with the last flag alongside
    grad_t              fifo_mem  [STREAM_CREDITS];
    logic               fifo_last [STREAM_CREDITS];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CRED_W-1:0]  fifo_cnt;

    logic [WCRED_W-1:0] wcred;
    addr_t              next_addr;
    // current write carries the final gradient
    logic               wr_last;
    logic               pop;

    // one write per cycle, only with a memory credit
    assign pop = (fifo_cnt != '0) && (wcred != '0);

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset || start) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fifo_cnt      <= '0;
            wcred         <= WCRED_W'(OUT_CREDITS);
            next_addr     <= '0;
            grad_addr     <= '0;
            grad_wr       <= 1'b0;
            wr_last       <= 1'b0;
            done          <= 1'b0;
            grad_s.credit <= 1'b0;
        end else begin
            if (grad_s.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr    <= rd_ptr + 1'b1;
                next_addr <= next_addr + 1'b1;
                grad_addr <= next_addr;
            end
            fifo_cnt <= fifo_cnt + CRED_W'(grad_s.valid) - CRED_W'(pop);
            // spend on pop, refund from outside, hold at the top
            if (pop && !grad_credit) begin
                wcred <= wcred - 1'b1;
            end else if (grad_credit && !pop && (wcred != '1)) begin
                wcred <= wcred + 1'b1;
            end
            grad_wr       <= pop;
            wr_last       <= pop && fifo_last[rd_ptr];
            grad_s.credit <= pop;
            // sticky until the next start
            done <= done || (grad_wr && wr_last);
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (grad_s.valid) begin
            fifo_mem[wr_ptr]  <= grad_s.data;
            fifo_last[wr_ptr] <= grad_s.last;
        end
        if (pop) begin
            grad_do <= fifo_mem[rd_ptr];
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // engine credits keep the fifo from overflowing
    a_fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
        grad_s.valid |-> (fifo_cnt != CRED_W'(STREAM_CREDITS)));

    // engine last flag and writer address agree on the final pixel
    a_last_addr: assert property (@(posedge clk) disable iff (reset)
        (grad_wr && wr_last) |-> (grad_addr == addr_t'(NUM_PIX - 1)));

endmodule

// File: rtl/ig_top.sv
`timescale 1ns/1ps

module ig_top
    import ig_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    // image memory
    output logic   img_rd,
    output addr_t  img_addr,
    input  pixel_t img_di,
    // gradient memory
    input  logic   grad_credit,
    output logic   grad_wr,
    output addr_t  grad_addr,
    output grad_t  grad_do,
    output logic   done
);

    // ----------------------------------------
    // internal streams
    // ----------------------------------------
    credit_stream_if #(.T(pixel_t)) pix_s ();
    credit_stream_if #(.T(grad_t))  grad_s ();

    // memory reads into pixel stream
    pixel_fetcher u_fetch (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di),
        .pix_s    (pix_s.src)
    );

    // row window, one gradient per pixel
    gradient_engine u_engine (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .pix_s  (pix_s.snk),
        .grad_s (grad_s.src)
    );

    // gradient memory writes under external credits
    grad_writer u_writer (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .grad_s      (grad_s.snk),
        .grad_credit (grad_credit),
        .grad_wr     (grad_wr),
        .grad_addr   (grad_addr),
        .grad_do     (grad_do),
        .done        (done)
    );

endmodule

// File: verification/ig_tb.sv
`timescale 1ns/1ps

module ig_tb
    import ig_pkg::*;
();

    // three runs, eight cycles a pixel is ample even under back-pressure
    localparam int TIMEOUT_CYCLES = 3 * NUM_PIX * 8 + 200;
    // quiet cycles watched after done
    localparam int POST_CYCLES = 8;

    logic   clk = 1'b0;
    logic   reset;
    logic   start;
    logic   img_rd;
    addr_t  img_addr;
    pixel_t img_di;
    logic   grad_credit;
    logic   grad_wr;
    addr_t  grad_addr;
    grad_t  grad_do;
    logic   done;

    // stall length, then the pixels
    logic [31:0] stim_mem [0:NUM_PIX];
    pixel_t      img [NUM_PIX];
    logic [31:0] lfsr_state = 32'h27fbd4d6;
    int          err_cnt    = 0;
    int          fail_tests = 0;
    int          test_cnt   = 0;
    int          cycle_cnt  = 0;

    ig_top UUT (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .img_rd      (img_rd),
        .img_addr    (img_addr),
        .img_di      (img_di),
        .grad_credit (grad_credit),
        .grad_wr     (grad_wr),
        .grad_addr   (grad_addr),
        .grad_do     (grad_do),
        .done        (done)
    );

    always #20 clk = ~clk;

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR at %0t: timeout, run did not finish in %0d cycles",
                     $time, TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    task automatic draw_bits(input int n, output logic [31:0] v);
        logic fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
    endtask

    // forward differences, zero where the neighbour is missing
    function automatic grad_t expected_grad(input int i);
        grad_t g;
        int    col;
        int    row;
        col  = i % IMG_W;
        row  = i / IMG_W;
        g.gx = '0;
        g.gy = '0;
        if (col != IMG_W - 1) begin
            g.gx = GRAD_W'(int'(img[i + 1]) - int'(img[i]));
        end
        if (row != IMG_H - 1) begin
            g.gy = GRAD_W'(int'(img[i + IMG_W]) - int'(img[i]));
        end
        return g;
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_grad(input string sig, input grad_t exp, input grad_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected gx=%0d gy=%0d, got gx=%0d gy=%0d",
                     $time, sig, exp.gx, exp.gy, act.gx, act.gy);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input string sig, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, sig, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, sig, exp, act);
            err_cnt++;
        end
    endtask

    // one image from start pulse to quiet after done
    task automatic run_image(input string name, input bit pressure, input int stall_len);
        int          errs_before;
        int          wr_cnt;
        int          rd_cnt;
        int          cred_cnt;
        int          post_cnt;
        int          cyc;
        logic        rd_pend;
        addr_t       rd_pend_addr;
        logic [31:0] bits;
        errs_before = err_cnt;
        wr_cnt      = 0;
        rd_cnt      = 0;
        cred_cnt    = 0;
        post_cnt    = 0;
        cyc         = 0;
        rd_pend     = 1'b0;
        test_cnt++;
        start       = 1'b1;
        grad_credit = !pressure;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (post_cnt < POST_CYCLES) begin
            // done follows the writes seen so far
            check_flag("done", wr_cnt >= NUM_PIX, done);
            if (wr_cnt >= NUM_PIX) begin
                check_flag("img_rd", 1'b0, img_rd);
                check_flag("grad_wr", 1'b0, grad_wr);
                post_cnt++;
            end
            if (img_rd) begin
                if (rd_cnt >= NUM_PIX) begin
                    $display("ERROR at %0t: image memory read beyond the last pixel", $time);
                    err_cnt++;
                end else begin
                    check_addr("img_addr", addr_t'(rd_cnt), img_addr);
                end
                rd_cnt++;
            end
            if (grad_wr) begin
                if (wr_cnt >= NUM_PIX) begin
                    $display("ERROR at %0t: gradient written after the final address", $time);
                    err_cnt++;
                end else begin
                    check_addr("grad_addr", addr_t'(wr_cnt), grad_addr);
                    check_grad("grad_do", expected_grad(wr_cnt), grad_do);
                end
                wr_cnt++;
                if (pressure && (wr_cnt > OUT_CREDITS + cred_cnt)) begin
                    $display("ERROR at %0t: %0d writes with only %0d credits returned",
                             $time, wr_cnt, cred_cnt);
                    err_cnt++;
                end
            end
            // image memory answers the read of the previous cycle
            if (rd_pend) begin
                img_di = img[rd_pend_addr];
            end
            rd_pend      = img_rd;
            rd_pend_addr = img_addr;
            // stall first, then random credits
            if (pressure) begin
                if (cyc < stall_len) begin
                    grad_credit = 1'b0;
                end else begin
                    draw_bits(1, bits);
                    grad_credit = bits[0];
                end
                cred_cnt += int'(grad_credit);
            end
            cyc++;
            @(posedge clk);
            #1;
        end
        if (rd_cnt != NUM_PIX) begin
            $display("ERROR at %0t: image memory read %0d times instead of %0d",
                     $time, rd_cnt, NUM_PIX);
            err_cnt++;
        end
        grad_credit = 1'b1;
        if (err_cnt != errs_before) begin
            fail_tests++;
        end
        $display("test %0d %-10s %0d writes in %0d cycles, %0d errors",
                 test_cnt, name, wr_cnt, cyc, err_cnt - errs_before);
    endtask

    // ----------------------------------------
    // sequence
    // ----------------------------------------
    initial begin
        logic [31:0] bits;
        reset       = 1'b1;
        start       = 1'b0;
        img_di      = '0;
        grad_credit = 1'b0;
        $readmemh("verification/ig_stim.txt", stim_mem);
        if ($isunknown(stim_mem[0])) begin
            $display("ERROR: stim file could not be read");
            err_cnt++;
        end
        for (int i = 0; i < NUM_PIX; i++) begin
            img[i] = pixel_t'(stim_mem[i + 1]);
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        run_image("stim", 1'b0, 0);
        run_image("pressure", 1'b1, int'(stim_mem[0]));
        // second image from the lfsr
        for (int i = 0; i < NUM_PIX; i++) begin
            draw_bits(PIX_W, bits);
            img[i] = pixel_t'(bits);
        end
        run_image("restart", 1'b0, 0);
        $display("summary: %0d tests, %0d failing, %0d errors", test_cnt, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verification/ig_stim.txt
// word 0: grad_credit stall length in cycles, then 64 pixels in raster order
30
00
10
20
30
40
50
60
70
08
ff
18
28
00
48
58
68
80
7f
90
a0
b0
c0
d0
e0
11
22
33
44
55
66
77
88
f0
e0
d0
c0
b0
a0
90
80
05
fa
0a
f5
0f
f0
14
eb
3c
3c
3c
3c
3c
3c
3c
3c
99
00
ff
01
fe
02
fd
03

// File: flist.f
rtl/ig_pkg.sv
rtl/credit_stream_if.sv
rtl/pixel_fetcher.sv
rtl/gradient_engine.sv
rtl/grad_writer.sv
rtl/ig_top.sv
verification/ig_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = ig_tb
FLIST    = flist.f
OBJ_DIR  = obj_dir
PASS_MSG = Verification passed

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# run and search the output for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
